// File: vlog.f
pixel_pkg.sv
scan_pkg.sv
scan_ctrl.sv
line_window.sv
edge_kernel.sv
edge_detect_top.sv
tb_edge_detect.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -Wall
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_edge_detect
FLIST      = vlog.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

# The log decides pass or fail, not the exit status of the binary
run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_edge_detect.sv
module tb_edge_detect;

   import pixel_pkg::*;
   import scan_pkg::*;

   localparam int W            = 8;
   localparam int H            = 6;
   localparam int NPIX         = W * H;
   localparam int IDX_W        = $clog2(NPIX);
   localparam int FRAME_CYCLES = (W + 1) * (H + 1) + 3;
   localparam int RESET_CYCLES = 5;
   localparam int FRAMES       = 6;
   localparam int LIMIT        = 2 * FRAMES * FRAME_CYCLES + RESET_CYCLES;

   logic   clk_40 = 1'b0;
   logic   rst_n;
   logic   start;
   logic   busy;
   logic   done;
   logic   src_rd;
   addr_t  src_addr;
   pixel_t src_pix_r = '0;
   pixel_t src_pix_g = '0;
   pixel_t src_pix_b = '0;
   logic   dst_wr;
   addr_t  dst_addr;
   pixel_t dst_pix_r;
   pixel_t dst_pix_g;
   pixel_t dst_pix_b;

   // Channel order r, g, b
   pixel_t src_mem [3][NPIX];
   pixel_t dst_mem [3][NPIX];
   int     wr_count [NPIX];
   int     wr_base [NPIX];
   int     rd_total = 0;
   int     rd_base = 0;
   int     cycle_count = 0;
   string  test_name = "reset";

   edge_detect_top #(
      .IMG_WIDTH  (W),
      .IMG_HEIGHT (H)
   ) i_dut (
      .clk_40    (clk_40),
      .rst_n     (rst_n),
      .start     (start),
      .busy      (busy),
      .done      (done),
      .src_rd    (src_rd),
      .src_addr  (src_addr),
      .src_pix_r (src_pix_r),
      .src_pix_g (src_pix_g),
      .src_pix_b (src_pix_b),
      .dst_wr    (dst_wr),
      .dst_addr  (dst_addr),
      .dst_pix_r (dst_pix_r),
      .dst_pix_g (dst_pix_g),
      .dst_pix_b (dst_pix_b)
   );

   always #20 clk_40 = ~clk_40;

   //////////////////////////////////////////////////////////////////////
   // Error handling
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_equal(string what, int expected, int actual);
      assert (actual == expected)
      else
      begin
         $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_true(bit cond, string msg);
      assert (cond)
      else
      begin
         $display("Error in test %s: %s", test_name, msg);
         abort_run();
      end
   endtask

   always @(posedge clk_40)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > LIMIT)
      begin
         $display("Timeout: the DUT did not finish within %0d cycles", LIMIT);
         abort_run();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Source and destination memories
   //////////////////////////////////////////////////////////////////////

   // Source answers one cycle after the read strobe
   always @(posedge clk_40)
   begin
      if (src_rd)
      begin
         check_true(rd_total - rd_base < NPIX, "more source reads than pixels in a frame");
         check_equal("read address", rd_total - rd_base, int'(src_addr));
         src_pix_r <= src_mem[0][src_addr[IDX_W-1:0]];
         src_pix_g <= src_mem[1][src_addr[IDX_W-1:0]];
         src_pix_b <= src_mem[2][src_addr[IDX_W-1:0]];
         rd_total  <= rd_total + 1;
      end
   end

   always @(posedge clk_40)
   begin
      if (dst_wr)
      begin
         check_true(int'(dst_addr) < NPIX, "write address outside the image");
         dst_mem[0][dst_addr[IDX_W-1:0]] <= dst_pix_r;
         dst_mem[1][dst_addr[IDX_W-1:0]] <= dst_pix_g;
         dst_mem[2][dst_addr[IDX_W-1:0]] <= dst_pix_b;
         wr_count[dst_addr[IDX_W-1:0]]   <= wr_count[dst_addr[IDX_W-1:0]] + 1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Zero outside the image
   function automatic int src_at(int ch, int r, int c);
      if (r < 0 || r >= H || c < 0 || c >= W)
         return 0;
      return int'(src_mem[ch][r * W + c]);
   endfunction

   function automatic int model_pix(int ch, int r, int c);
      int acc;
      acc = 8 * src_at(ch, r, c);
      for (int dr = -1; dr <= 1; dr++)
      begin
         for (int dc = -1; dc <= 1; dc++)
         begin
            if (dr != 0 || dc != 0)
               acc = acc - src_at(ch, r + dr, c + dc);
         end
      end
      if (acc < 0)
         return 0;
      if (acc > 15)
         return 15;
      return acc;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Frame helpers
   //////////////////////////////////////////////////////////////////////

   task automatic fill_const(pixel_t v);
      for (int a = 0; a < NPIX; a++)
      begin
         for (int ch = 0; ch < 3; ch++)
            src_mem[ch][a] = v;
      end
   endtask

   task automatic fill_random();
      for (int a = 0; a < NPIX; a++)
      begin
         for (int ch = 0; ch < 3; ch++)
            src_mem[ch][a] = pixel_t'($urandom & 32'hf);
      end
   endtask

   // Pulses start, optionally again mid-frame, and checks the done and busy timing
   task automatic run_frame(bit mid_start);
      int elapsed;
      for (int a = 0; a < NPIX; a++)
         wr_base[a] = wr_count[a];
      rd_base = rd_total;
      start <= 1'b1;
      @(posedge clk_40);
      start   <= 1'b0;
      elapsed = 0;
      @(posedge clk_40);
      elapsed++;
      check_true(busy, "busy did not rise the cycle after start");
      do
      begin
         @(posedge clk_40);
         elapsed++;
         start <= mid_start && (elapsed == FRAME_CYCLES / 2);
      end
      while (!done);
      check_true(dst_wr && int'(dst_addr) == NPIX - 1, "done not aligned with the last write");
      check_equal("frame length", FRAME_CYCLES, elapsed);
      @(posedge clk_40);
      check_true(!busy, "busy did not fall the cycle after done");
      check_true(!done, "done held for more than one cycle");
   endtask

   task automatic check_frame();
      check_equal("source reads", NPIX, rd_total - rd_base);
      for (int a = 0; a < NPIX; a++)
      begin
         check_equal($sformatf("writes to %0d", a), 1, wr_count[a] - wr_base[a]);
         for (int ch = 0; ch < 3; ch++)
         begin
            check_equal($sformatf("ch %0d addr %0d", ch, a),
                        model_pix(ch, a / W, a % W), int'(dst_mem[ch][a]));
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_flat();
      bit border;
      test_name = "flat";
      fill_const(pixel_t'(5));
      run_frame(1'b0);
      check_frame();
      for (int a = 0; a < NPIX; a++)
      begin
         border = (a / W == 0) || (a / W == H - 1) || (a % W == 0) || (a % W == W - 1);
         for (int ch = 0; ch < 3; ch++)
         begin
            if (border)
               check_true(dst_mem[ch][a] != '0, "edge result not positive");
            else
               check_equal($sformatf("interior %0d", a), 0, int'(dst_mem[ch][a]));
         end
      end
   endtask

   task automatic test_bright();
      test_name = "bright";
      fill_const('0);
      for (int ch = 0; ch < 3; ch++)
         src_mem[ch][3 * W + 4] = pixel_t'(15);
      run_frame(1'b0);
      check_frame();
      for (int a = 0; a < NPIX; a++)
      begin
         for (int ch = 0; ch < 3; ch++)
         begin
            check_equal($sformatf("ch %0d addr %0d", ch, a),
                        (a == 3 * W + 4) ? 15 : 0, int'(dst_mem[ch][a]));
         end
      end
   endtask

   task automatic test_random();
      test_name = "random";
      fill_random();
      run_frame(1'b0);
      check_frame();
   endtask

   // Pattern uses every address bit
   task automatic test_addressing();
      test_name = "addressing";
      for (int a = 0; a < NPIX; a++)
      begin
         for (int ch = 0; ch < 3; ch++)
            src_mem[ch][a] = pixel_t'((a + 3 * (a >> 4) + 5 * ch) & 15);
      end
      run_frame(1'b0);
      check_frame();
   endtask

   task automatic test_back_to_back();
      test_name = "back_to_back";
      fill_random();
      run_frame(1'b0);
      check_frame();
      fill_random();
      run_frame(1'b1);
      check_frame();
   endtask

   initial
   begin
      rst_n <= 1'b0;
      start <= 1'b0;
      void'($urandom(32'ha1d3));
      repeat (RESET_CYCLES) @(posedge clk_40);
      rst_n <= 1'b1;
      @(posedge clk_40);
      check_true(!src_rd && !dst_wr && !busy && !done, "outputs not low after reset");
      test_flat();
      test_bright();
      test_random();
      test_addressing();
      test_back_to_back();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: edge_detect_top.sv
module edge_detect_top
#(
   parameter int IMG_WIDTH  = 400,
   parameter int IMG_HEIGHT = 300
)
(
   input  logic              clk_40,
   input  logic              rst_n,
   input  logic              start,
   output logic              busy,
   output logic              done,
   output logic              src_rd,
   output scan_pkg::addr_t   src_addr,
   input  pixel_pkg::pixel_t src_pix_r,
   input  pixel_pkg::pixel_t src_pix_g,
   input  pixel_pkg::pixel_t src_pix_b,
   output logic              dst_wr,
   output scan_pkg::addr_t   dst_addr,
   output pixel_pkg::pixel_t dst_pix_r,
   output pixel_pkg::pixel_t dst_pix_g,
   output pixel_pkg::pixel_t dst_pix_b
);

   import pixel_pkg::*;
   import scan_pkg::*;

   logic   load;
   logic   load_virtual;
   logic   pad_top;
   logic   pad_left;
   coord_t load_col;

   // Channel order r, g, b
   pixel_t src_pix [3];
   pixel_t dst_pix [3];
   pixel_t tap [3][9];

   assign src_pix[0] = src_pix_r;
   assign src_pix[1] = src_pix_g;
   assign src_pix[2] = src_pix_b;
   assign dst_pix_r  = dst_pix[0];
   assign dst_pix_g  = dst_pix[1];
   assign dst_pix_b  = dst_pix[2];

   scan_ctrl #(
      .IMG_WIDTH  (IMG_WIDTH),
      .IMG_HEIGHT (IMG_HEIGHT)
   ) i_scan_ctrl (
      .clk_40       (clk_40),
      .rst_n        (rst_n),
      .start        (start),
      .busy         (busy),
      .done         (done),
      .src_rd       (src_rd),
      .src_addr     (src_addr),
      .load         (load),
      .load_virtual (load_virtual),
      .load_col     (load_col),
      .pad_top      (pad_top),
      .pad_left     (pad_left),
      .dst_wr       (dst_wr),
      .dst_addr     (dst_addr)
   );

   //////////////////////////////////////////////////////////////////////
   // One window and kernel per colour channel
   //////////////////////////////////////////////////////////////////////

   for (genvar ch = 0; ch < 3; ch++)
   begin : g_channel
      line_window #(
         .IMG_WIDTH (IMG_WIDTH)
      ) i_line_window (
         .clk_40       (clk_40),
         .rst_n        (rst_n),
         .pix_in       (src_pix[ch]),
         .load         (load),
         .load_virtual (load_virtual),
         .load_col     (load_col),
         .pad_top      (pad_top),
         .pad_left     (pad_left),
         .tap_0        (tap[ch][0]),
         .tap_1        (tap[ch][1]),
         .tap_2        (tap[ch][2]),
         .tap_3        (tap[ch][3]),
         .tap_4        (tap[ch][4]),
         .tap_5        (tap[ch][5]),
         .tap_6        (tap[ch][6]),
         .tap_7        (tap[ch][7]),
         .tap_8        (tap[ch][8])
      );

      edge_kernel i_edge_kernel (
         .clk_40 (clk_40),
         .rst_n  (rst_n),
         .tap_0  (tap[ch][0]),
         .tap_1  (tap[ch][1]),
         .tap_2  (tap[ch][2]),
         .tap_3  (tap[ch][3]),
         .tap_4  (tap[ch][4]),
         .tap_5  (tap[ch][5]),
         .tap_6  (tap[ch][6]),
         .tap_7  (tap[ch][7]),
         .tap_8  (tap[ch][8]),
         .pix    (dst_pix[ch])
      );
   end

endmodule

// File: edge_kernel.sv
module edge_kernel
(
   input  logic              clk_40,
   input  logic              rst_n,
   input  pixel_pkg::pixel_t tap_0,
   input  pixel_pkg::pixel_t tap_1,
   input  pixel_pkg::pixel_t tap_2,
   input  pixel_pkg::pixel_t tap_3,
   input  pixel_pkg::pixel_t tap_4,
   input  pixel_pkg::pixel_t tap_5,
   input  pixel_pkg::pixel_t tap_6,
   input  pixel_pkg::pixel_t tap_7,
   input  pixel_pkg::pixel_t tap_8,
   output pixel_pkg::pixel_t pix
);

   import pixel_pkg::*;

   kernel_sum_t neigh_sum;
   kernel_sum_t centre;
   kernel_sum_t acc;
   pixel_t      clamped;

   always_comb
   begin
      neigh_sum = kernel_sum_t'(tap_0) + kernel_sum_t'(tap_1) + kernel_sum_t'(tap_2)
                + kernel_sum_t'(tap_3) + kernel_sum_t'(tap_5)
                + kernel_sum_t'(tap_6) + kernel_sum_t'(tap_7) + kernel_sum_t'(tap_8);
      centre    = CENTRE_GAIN * kernel_sum_t'(tap_4);
      acc       = centre - neigh_sum;
   end

   // Saturate to the sample range
   always_comb
   begin
      if (acc < 0)
         clamped = '0;
      else if (acc > kernel_sum_t'(PIX_MAX))
         clamped = PIX_MAX;
      else
         clamped = acc[PIX_W-1:0];
   end

   always_ff @(posedge clk_40 or negedge rst_n)
   begin
      if (!rst_n)
         pix <= '0;
      else
         pix <= clamped;
   end

endmodule

// File: line_window.sv
module line_window
#(
   parameter int IMG_WIDTH = 400
)
(
   input  logic              clk_40,
   input  logic              rst_n,
   input  pixel_pkg::pixel_t pix_in,
   input  logic              load,
   input  logic              load_virtual,
   input  scan_pkg::coord_t  load_col,
   input  logic              pad_top,
   input  logic              pad_left,
   output pixel_pkg::pixel_t tap_0,
   output pixel_pkg::pixel_t tap_1,
   output pixel_pkg::pixel_t tap_2,
   output pixel_pkg::pixel_t tap_3,
   output pixel_pkg::pixel_t tap_4,
   output pixel_pkg::pixel_t tap_5,
   output pixel_pkg::pixel_t tap_6,
   output pixel_pkg::pixel_t tap_7,
   output pixel_pkg::pixel_t tap_8
);

   import pixel_pkg::*;
   import scan_pkg::*;

   localparam int COL_W = $clog2(IMG_WIDTH);

   // Two rows back and one row back
   pixel_t line_old [IMG_WIDTH];
   pixel_t line_new [IMG_WIDTH];

   // Row-major 3x3 window, newest column on the right
   pixel_t win [9];

   logic             col_ok;
   logic [COL_W-1:0] col_idx;
   pixel_t           col_top;
   pixel_t           col_mid;
   pixel_t           col_bot;

   // Virtual last column has no line-store entry
   assign col_ok  = (load_col < coord_t'(IMG_WIDTH));
   assign col_idx = load_col[COL_W-1:0];

   always_comb
   begin
      col_top = '0;
      col_mid = '0;
      if (col_ok)
      begin
         col_top = line_old[col_idx];
         col_mid = line_new[col_idx];
      end
   end

   assign col_bot = load_virtual ? '0 : pix_in;

   //////////////////////////////////////////////////////////////////////
   // Line-store cascade
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_40)
   begin
      if (load && col_ok)
      begin
         line_old[col_idx] <= col_mid;
         line_new[col_idx] <= col_bot;
      end
   end

   // Shift one column into the window per load
   always_ff @(posedge clk_40 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 9; i++)
         begin
            win[i] <= '0;
         end
      end
      else if (load)
      begin
         win[0] <= win[1];
         win[1] <= win[2];
         win[2] <= col_top;
         win[3] <= win[4];
         win[4] <= win[5];
         win[5] <= col_mid;
         win[6] <= win[7];
         win[7] <= win[8];
         win[8] <= col_bot;
      end
   end

   // Top and left borders masked here, bottom and right arrive as zeros
   assign tap_0 = (pad_top || pad_left) ? '0 : win[0];
   assign tap_1 = pad_top ? '0 : win[1];
   assign tap_2 = pad_top ? '0 : win[2];
   assign tap_3 = pad_left ? '0 : win[3];
   assign tap_4 = win[4];
   assign tap_5 = win[5];
   assign tap_6 = pad_left ? '0 : win[6];
   assign tap_7 = win[7];
   assign tap_8 = win[8];

endmodule

// File: scan_ctrl.sv
module scan_ctrl
#(
   parameter int IMG_WIDTH  = 400,
   parameter int IMG_HEIGHT = 300
)
(
   input  logic             clk_40,
   input  logic             rst_n,
   input  logic             start,
   output logic             busy,
   output logic             done,
   output logic             src_rd,
   output scan_pkg::addr_t  src_addr,
   output logic             load,
   output logic             load_virtual,
   output scan_pkg::coord_t load_col,
   output logic             pad_top,
   output logic             pad_left,
   output logic             dst_wr,
   output scan_pkg::addr_t  dst_addr
);

   import scan_pkg::*;

   localparam coord_t LAST_ROW = coord_t'(IMG_HEIGHT);
   localparam coord_t LAST_COL = coord_t'(IMG_WIDTH);

   scan_state_e state;
   coord_t      row;
   coord_t      col;
   addr_t       rd_addr;
   addr_t       wr_addr;
   logic        step;
   logic        in_image;
   logic        res_step;
   logic        last_step;

   logic [PIPE_DEPTH:1]   res_q;
   logic [PIPE_DEPTH:1]   last_q;
   addr_t                 addr_q [PIPE_DEPTH:1];
   logic [PIPE_DEPTH-1:1] top_q;
   logic [PIPE_DEPTH-1:1] left_q;

   // Scan step, one grid position per cycle
   assign step      = (state == SCAN);
   assign in_image  = (row < LAST_ROW) && (col < LAST_COL);
   // Row 0 and column 0 only prime the window
   assign res_step  = step && (row != '0) && (col != '0);
   assign last_step = (row == LAST_ROW) && (col == LAST_COL);

   assign src_rd   = step && in_image;
   assign src_addr = rd_addr;
   assign busy     = (state != IDLE);

   //////////////////////////////////////////////////////////////////////
   // Frame FSM over the extended grid
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_40 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= IDLE;
         row     <= '0;
         col     <= '0;
         rd_addr <= '0;
         wr_addr <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (start)
               begin
                  state   <= SCAN;
                  row     <= '0;
                  col     <= '0;
                  rd_addr <= '0;
                  wr_addr <= '0;
               end
            end
            SCAN:
            begin
               if (src_rd)
                  rd_addr <= rd_addr + 1'b1;
               if (res_step)
                  wr_addr <= wr_addr + 1'b1;
               if (col == LAST_COL)
               begin
                  col <= '0;
                  row <= row + 1'b1;
                  if (row == LAST_ROW)
                     state <= DRAIN;
               end
               else
               begin
                  col <= col + 1'b1;
               end
            end
            DRAIN:
            begin
               // Wait for the last result write
               if (done)
                  state <= IDLE;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Per-position delay line to load, window and write stages
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_40 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         load         <= 1'b0;
         load_virtual <= 1'b0;
         load_col     <= '0;
         res_q        <= '0;
         last_q       <= '0;
         top_q        <= '0;
         left_q       <= '0;
      end
      else
      begin
         // Source data returns one cycle after the read
         load         <= step;
         load_virtual <= step && !in_image;
         load_col     <= col;
         res_q        <= {res_q[PIPE_DEPTH-1:1], res_step};
         last_q       <= {last_q[PIPE_DEPTH-1:1], step && last_step};
         top_q        <= {top_q[PIPE_DEPTH-2:1], row == coord_t'(1)};
         left_q       <= {left_q[PIPE_DEPTH-2:1], col == coord_t'(1)};
      end
   end

   always_ff @(posedge clk_40)
   begin
      addr_q[1] <= wr_addr;
      for (int i = 2; i <= PIPE_DEPTH; i++)
      begin
         addr_q[i] <= addr_q[i-1];
      end
   end

   // Centre row or column 0 sits on the top or left border
   assign pad_top  = top_q[PIPE_DEPTH-1];
   assign pad_left = left_q[PIPE_DEPTH-1];

   assign dst_wr   = res_q[PIPE_DEPTH];
   assign dst_addr = addr_q[PIPE_DEPTH];
   assign done     = last_q[PIPE_DEPTH];

endmodule

// File: scan_pkg.sv
package scan_pkg;

   //////////////////////////////////////////////////////////////////////
   // Frame sequencing
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0]
   {
      IDLE,
      SCAN,
      DRAIN
   } scan_state_e;

   // Row or column index, includes the virtual last row and column
   typedef logic [9:0] coord_t;

   // Linear pixel address into source or destination memory
   typedef logic [17:0] addr_t;

   // Read, load, kernel register
   localparam int PIPE_DEPTH = 3;

endpackage

// File: pixel_pkg.sv
package pixel_pkg;

   //////////////////////////////////////////////////////////////////////
   // Colour samples
   //////////////////////////////////////////////////////////////////////

   // Width of one colour channel
   localparam int PIX_W = 4;

   typedef logic [PIX_W-1:0] pixel_t;

   // Upper clamp limit of the filter output
   localparam pixel_t PIX_MAX = pixel_t'(15);

   //////////////////////////////////////////////////////////////////////
   // Laplacian kernel arithmetic
   //////////////////////////////////////////////////////////////////////

   // Holds 8 x 15 down to -(8 x 15) without overflow
   typedef logic signed [8:0] kernel_sum_t;

   // Weight of the centre tap, neighbours weigh -1
   localparam kernel_sum_t CENTRE_GAIN = kernel_sum_t'(8);

endpackage
